// ==== hdl/msg_pkg.sv ====
package msg_pkg;

    //////////////////////////////////////////////////
    // Sizes

    localparam int BYTE_W        = 8;
    localparam int MSG_MAX       = 24;
    localparam int LEN_W         = 5;
    localparam int SETTLE_CYCLES = 3;
    localparam int SETTLE_W      = $clog2(SETTLE_CYCLES);

    localparam logic [BYTE_W-1:0] CHAR_LF = 8'h0A;

    typedef logic [BYTE_W-1:0] byte_t;

    // ASCII digits as shown by the clock core
    typedef struct packed {
        byte_t hour_10;
        byte_t hour_1;
        byte_t min_10;
        byte_t min_1;
        byte_t sec_10;
        byte_t sec_1;
    } time_digits_t;

    typedef enum logic [3:0] {
        MODE_CLOCK     = 4'b0000,
        MODE_STOPWATCH = 4'b0001,
        MODE_TIMER     = 4'b0010
    } mode_t;

    typedef struct packed {
        logic left;
        logic right;
    } btn_t;

    typedef enum logic [3:0] {
        MSG_CLOCK_RPT,
        MSG_SW_RPT,
        MSG_TIMER_RPT,
        MSG_SW_RUN,
        MSG_SW_STOP,
        MSG_SW_CLEAR,
        MSG_TIMER_RUN,
        MSG_TIMER_STOP,
        MSG_TIMER_CLEAR,
        MSG_SET_ON,
        MSG_SET_OFF
    } msg_kind_t;

    typedef struct packed {
        byte_t [MSG_MAX-1:0] data;  // data[0] goes out first
        logic  [LEN_W-1:0]   len;
    } msg_t;

    //////////////////////////////////////////////////
    // Templates

    // Text of n chars, left char in the top byte, LF appended
    function automatic msg_t make_msg(input logic [MSG_MAX*BYTE_W-1:0] txt, input int n);
        msg_t m;
        m.data = '0;
        for (int i = 0; i < MSG_MAX; i++) begin
            if (i < n)
                m.data[i] = txt[(n - 1 - i) * BYTE_W +: BYTE_W];
            else if (i == n)
                m.data[i] = CHAR_LF;
        end
        m.len = LEN_W'(n + 1);
        return m;
    endfunction

    function automatic msg_t msg_template(input msg_kind_t kind);
        case (kind)
            MSG_CLOCK_RPT   : return make_msg("Clock 00H 00M 00S", 17);
            MSG_SW_RPT      : return make_msg("Stopwatch 00M 00S 00mS", 22);
            MSG_TIMER_RPT   : return make_msg("Timer 00H 00M 00S", 17);
            MSG_SW_RUN      : return make_msg("Stop_Watch_RUN", 14);
            MSG_SW_STOP     : return make_msg("Stop_Watch_STOP", 15);
            MSG_SW_CLEAR    : return make_msg("Stop_Watch_Clear", 16);
            MSG_TIMER_RUN   : return make_msg("Timer_RUN", 9);
            MSG_TIMER_STOP  : return make_msg("Timer_STOP", 10);
            MSG_TIMER_CLEAR : return make_msg("Timer_Clear", 11);
            MSG_SET_ON      : return make_msg("Setting_On", 10);
            MSG_SET_OFF     : return make_msg("Setting_Off", 11);
            default         : return make_msg("", 0);  // LF only
        endcase
    endfunction

    function automatic logic is_report(input msg_kind_t kind);
        return (kind == MSG_CLOCK_RPT) || (kind == MSG_SW_RPT) || (kind == MSG_TIMER_RPT);
    endfunction

    // Position of the first hour digit, pairs follow every 4 bytes
    function automatic logic [LEN_W-1:0] digit_base(input msg_kind_t kind);
        if (kind == MSG_SW_RPT)
            return LEN_W'(10);
        else
            return LEN_W'(6);
    endfunction

endpackage

// ==== hdl/request_decoder.sv ====
`timescale 1ns/1ps

module request_decoder (
    input  logic                  iClk,
    input  logic                  iRst,
    input  logic                  rx_valid,
    input  msg_pkg::byte_t        rx_data,
    output logic                  rx_ready,
    input  msg_pkg::mode_t        mode,
    input  logic                  set,
    input  msg_pkg::btn_t         btn,
    input  msg_pkg::time_digits_t digits,
    output logic                  req_valid,
    output msg_pkg::msg_kind_t    req_kind,
    input  logic                  req_ready
);
    import msg_pkg::*;

    logic      rx_fire;
    logic      one_btn;
    logic      digits_zero;
    logic      ev_valid;
    msg_kind_t ev_kind;
    logic      sw_run;
    logic      sw_run_n;
    logic      tmr_run;
    logic      tmr_run_n;
    logic      set_on;
    logic      set_on_n;

    assign rx_ready    = !req_valid;    // Free while nothing waits
    assign rx_fire     = rx_valid && rx_ready;
    assign one_btn     = btn.left ^ btn.right;
    assign digits_zero = (digits == {6{"0"}});

    //////////////////////////////////////////////////
    // Event decode

    always_comb begin
        ev_valid  = 1'b0;
        ev_kind   = MSG_CLOCK_RPT;
        sw_run_n  = sw_run;
        tmr_run_n = tmr_run;
        set_on_n  = set_on;

        if (rx_fire) begin
            case (rx_data)
                "C": begin
                    ev_valid = 1'b1;
                    ev_kind  = MSG_CLOCK_RPT;
                end
                "W": begin
                    ev_valid = 1'b1;
                    ev_kind  = MSG_SW_RPT;
                end
                "T": begin
                    ev_valid = 1'b1;
                    ev_kind  = MSG_TIMER_RPT;
                end
                "S": begin
                    set_on_n = !set_on;
                    ev_valid = 1'b1;
                    ev_kind  = set_on_n ? MSG_SET_ON : MSG_SET_OFF;
                end
                default: ;  // Not a command
            endcase
        end else if (!req_valid && one_btn) begin
            if (mode == MODE_STOPWATCH) begin
                ev_valid = 1'b1;
                if (btn.right) begin
                    sw_run_n = !sw_run;
                    ev_kind  = sw_run_n ? MSG_SW_RUN : MSG_SW_STOP;
                end else begin
                    ev_kind = MSG_SW_CLEAR;
                end
            end else if (mode == MODE_TIMER && !set) begin
                ev_valid = 1'b1;
                if (btn.right) begin
                    // Nothing left to count down
                    tmr_run_n = digits_zero ? 1'b0 : !tmr_run;
                    ev_kind   = tmr_run_n ? MSG_TIMER_RUN : MSG_TIMER_STOP;
                end else begin
                    ev_kind = MSG_TIMER_CLEAR;
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Flags and request register

    always_ff @(posedge iClk or posedge iRst) begin
        if (iRst) begin
            req_valid <= 1'b0;
            sw_run    <= 1'b0;
            tmr_run   <= 1'b0;
            set_on    <= 1'b0;
        end else begin
            sw_run  <= sw_run_n;
            tmr_run <= tmr_run_n;
            set_on  <= set_on_n;
            if (ev_valid)
                req_valid <= 1'b1;
            else if (req_ready)
                req_valid <= 1'b0;
        end
    end

    always_ff @(posedge iClk) begin
        if (ev_valid)
            req_kind <= ev_kind;
    end

    // A waiting request must not change under back-pressure
    a_req_hold: assert property (@(posedge iClk) disable iff (iRst)
        req_valid && !req_ready |=> req_valid && $stable(req_kind));

endmodule

// ==== hdl/msg_builder.sv ====
`timescale 1ns/1ps

module msg_builder (
    input  logic                  iClk,
    input  logic                  iRst,
    input  logic                  req_valid,
    input  msg_pkg::msg_kind_t    req_kind,
    output logic                  req_ready,
    input  msg_pkg::time_digits_t digits,
    output logic                  msg_valid,
    output msg_pkg::msg_t         msg,
    input  logic                  msg_ready
);
    import msg_pkg::*;

    typedef enum logic [1:0] {
        ST_FREE,
        ST_SETTLE,
        ST_FILL,
        ST_OFFER
    } state_t;

    state_t               state;
    logic [SETTLE_W-1:0]  settle_cnt;
    logic                 req_fire;
    logic                 settle_done;
    msg_kind_t            kind_r;
    msg_t                 msg_r;
    logic [LEN_W-1:0]     base;

    assign req_ready   = (state == ST_FREE);
    assign req_fire    = req_valid && req_ready;
    assign msg_valid   = (state == ST_OFFER);
    assign msg         = msg_r;
    assign base        = digit_base(kind_r);
    assign settle_done = (settle_cnt == SETTLE_W'(SETTLE_CYCLES - 2));

    //////////////////////////////////////////////////
    // FSM

    always_ff @(posedge iClk or posedge iRst) begin
        if (iRst) begin
            state      <= ST_FREE;
            settle_cnt <= '0;
        end else begin
            case (state)
                ST_FREE: begin
                    settle_cnt <= '0;
                    if (req_fire)
                        state <= is_report(req_kind) ? ST_SETTLE : ST_OFFER;
                end
                ST_SETTLE: begin
                    if (settle_done)
                        state <= ST_FILL;
                    else
                        settle_cnt <= settle_cnt + 1'b1;
                end
                ST_FILL: begin
                    state <= ST_OFFER;  // Digits sampled on this edge
                end
                ST_OFFER: begin
                    if (msg_ready)
                        state <= ST_FREE;
                end
                default: state <= ST_FREE;
            endcase
        end
    end

    //////////////////////////////////////////////////
    // Message register

    always_ff @(posedge iClk) begin
        if (req_fire) begin
            kind_r <= req_kind;
            msg_r  <= msg_template(req_kind);
        end else if (state == ST_FILL) begin
            msg_r.data[base]                <= digits.hour_10;
            msg_r.data[base + LEN_W'(1)]    <= digits.hour_1;
            msg_r.data[base + LEN_W'(4)]    <= digits.min_10;
            msg_r.data[base + LEN_W'(5)]    <= digits.min_1;
            msg_r.data[base + LEN_W'(8)]    <= digits.sec_10;
            msg_r.data[base + LEN_W'(9)]    <= digits.sec_1;
        end
    end

    // Offered message is sane for the streamer's index logic
    a_msg_len: assert property (@(posedge iClk) disable iff (iRst)
        msg_valid |-> (msg.len >= LEN_W'(1)) && (msg.len <= LEN_W'(MSG_MAX))
                      && (msg.data[msg.len - LEN_W'(1)] == CHAR_LF));

endmodule

// ==== hdl/tx_streamer.sv ====
`timescale 1ns/1ps

module tx_streamer (
    input  logic           iClk,
    input  logic           iRst,
    input  logic           msg_valid,
    input  msg_pkg::msg_t  msg,
    output logic           msg_ready,
    output logic           tx_valid,
    output msg_pkg::byte_t tx_data,
    input  logic           tx_ready
);
    import msg_pkg::*;

    logic             busy;
    logic [LEN_W-1:0] idx;
    msg_t             buf_r;
    logic             msg_fire;
    logic             tx_fire;
    logic             last_byte;

    assign msg_ready = !busy;
    assign msg_fire  = msg_valid && msg_ready;
    assign tx_valid  = busy;
    assign tx_fire   = tx_valid && tx_ready;
    assign tx_data   = buf_r.data[idx];
    assign last_byte = (idx == buf_r.len - LEN_W'(1));    // LF position

    //////////////////////////////////////////////////
    // Byte index

    always_ff @(posedge iClk or posedge iRst) begin
        if (iRst) begin
            busy <= 1'b0;
            idx  <= '0;
        end else if (msg_fire) begin
            busy <= 1'b1;
            idx  <= '0;
        end else if (tx_fire) begin
            if (last_byte)
                busy <= 1'b0;
            else
                idx <= idx + LEN_W'(1);
        end
    end

    always_ff @(posedge iClk) begin
        if (msg_fire)
            buf_r <= msg;
    end

    // UART side sees a steady byte until it takes it
    a_tx_hold: assert property (@(posedge iClk) disable iff (iRst)
        tx_valid && !tx_ready |=> tx_valid && $stable(tx_data));

endmodule

// ==== hdl/uart_msg_top.sv ====
`timescale 1ns/1ps

module uart_msg_top (
    input  logic                  iClk,
    input  logic                  iRst,
    input  logic                  rx_valid,
    input  msg_pkg::byte_t        rx_data,
    output logic                  rx_ready,
    input  msg_pkg::mode_t        mode,
    input  logic                  set,
    input  msg_pkg::btn_t         btn,
    input  msg_pkg::time_digits_t digits,
    output logic                  tx_valid,
    output msg_pkg::byte_t        tx_data,
    input  logic                  tx_ready
);
    import msg_pkg::*;

    logic      req_valid;
    logic      req_ready;
    msg_kind_t req_kind;
    logic      msg_valid;
    logic      msg_ready;
    msg_t      msg;

    //////////////////////////////////////////////////
    // Decoder, builder, streamer

    request_decoder u_decoder (
        .iClk      (iClk),
        .iRst      (iRst),
        .rx_valid  (rx_valid),
        .rx_data   (rx_data),
        .rx_ready  (rx_ready),
        .mode      (mode),
        .set       (set),
        .btn       (btn),
        .digits    (digits),
        .req_valid (req_valid),
        .req_kind  (req_kind),
        .req_ready (req_ready)
    );

    msg_builder u_builder (
        .iClk      (iClk),
        .iRst      (iRst),
        .req_valid (req_valid),
        .req_kind  (req_kind),
        .req_ready (req_ready),
        .digits    (digits),       // Sampled after settle delay
        .msg_valid (msg_valid),
        .msg       (msg),
        .msg_ready (msg_ready)
    );

    tx_streamer u_streamer (
        .iClk      (iClk),
        .iRst      (iRst),
        .msg_valid (msg_valid),
        .msg       (msg),
        .msg_ready (msg_ready),
        .tx_valid  (tx_valid),
        .tx_data   (tx_data),
        .tx_ready  (tx_ready)
    );

endmodule

// ==== test/tb_uart_msg.sv ====
`timescale 1ns/1ps

module tb_uart_msg;
    import msg_pkg::*;

    localparam int    WAIT_LIMIT   = 50;
    localparam int    LINE_LIMIT   = 400;    // Generous for random back-pressure
    localparam int    QUIET_CYCLES = 60;
    localparam byte_t LF           = 8'h0A;

    logic         iClk = 1'b0;
    logic         iRst;
    logic         rx_valid;
    byte_t        rx_data;
    logic         rx_ready;
    mode_t        mode;
    logic         set;
    btn_t         btn;
    time_digits_t digits;
    logic         tx_valid;
    byte_t        tx_data;
    logic         tx_ready = 1'b1;

    logic   bp_random = 1'b0;
    integer seed = 98;
    int     errors;
    int     tests_run;
    int     tests_failed;
    byte_t  tx_bytes[$];

    uart_msg_top UUT (
        .iClk     (iClk),
        .iRst     (iRst),
        .rx_valid (rx_valid),
        .rx_data  (rx_data),
        .rx_ready (rx_ready),
        .mode     (mode),
        .set      (set),
        .btn      (btn),
        .digits   (digits),
        .tx_valid (tx_valid),
        .tx_data  (tx_data),
        .tx_ready (tx_ready)
    );

    always #4 iClk = ~iClk;

    //////////////////////////////////////////////////
    // UART side model

    always @(posedge iClk) begin
        if (!iRst && tx_valid && tx_ready)
            tx_bytes.push_back(tx_data);
    end

    always @(posedge iClk) begin
        if (bp_random)
            tx_ready <= (($random(seed) & 1) != 0);
        else
            tx_ready <= 1'b1;
    end

    //////////////////////////////////////////////////
    // Helpers

    function automatic bit line_ready();
        foreach (tx_bytes[i]) begin
            if (tx_bytes[i] == LF)
                return 1'b1;
        end
        return 1'b0;
    endfunction

    // Six ASCII chars, hour tens first
    function automatic time_digits_t to_digits(input string d);
        time_digits_t t;
        t.hour_10 = d[0];
        t.hour_1  = d[1];
        t.min_10  = d[2];
        t.min_1   = d[3];
        t.sec_10  = d[4];
        t.sec_1   = d[5];
        return t;
    endfunction

    function automatic string report_text(input string title, input string d,
                                          input string u1, input string u2,
                                          input string u3);
        return {title, d.substr(0, 1), u1, d.substr(2, 3), u2, d.substr(4, 5), u3};
    endfunction

    task automatic send_cmd(input byte_t b);
        int cnt;
        bit taken;
        cnt   = 0;
        taken = 1'b0;
        @(posedge iClk);
        rx_valid <= 1'b1;
        rx_data  <= b;
        while (!taken && cnt < WAIT_LIMIT) begin
            @(posedge iClk);
            taken = rx_ready;   // Pre-edge value, so the byte went in here
            cnt++;
        end
        rx_valid <= 1'b0;
        assert (taken) else begin
            $display("Error: command byte %c was never accepted", b);
            errors++;
        end
    endtask

    task automatic press_btn(input btn_t b);
        int cnt;
        cnt = 0;
        @(posedge iClk);
        while (!rx_ready && cnt < WAIT_LIMIT) begin
            @(posedge iClk);
            cnt++;
        end
        assert (rx_ready) else begin
            $display("Error: decoder stayed busy, button press was not driven");
            errors++;
        end
        btn <= b;
        @(posedge iClk);
        btn <= '0;
    endtask

    task automatic compare_line(input string txt);
        string exp_s;
        byte_t line[$];
        byte_t b;
        int    cnt;
        exp_s = {txt, "\n"};
        cnt   = 0;
        while (!line_ready() && cnt < LINE_LIMIT) begin
            @(negedge iClk);
            cnt++;
        end
        assert (line_ready()) else begin
            $display("Error: no full line within %0d cycles, expected %s", LINE_LIMIT, txt);
            errors++;
        end
        if (line_ready()) begin
            do begin
                b = tx_bytes.pop_front();
                line.push_back(b);
            end while (b != LF);
            assert (line.size() == exp_s.len()) else begin
                $display("Error: line has %0d bytes where %0d were expected",
                         line.size(), exp_s.len());
                errors++;
            end
            for (int i = 0; i < line.size() && i < exp_s.len(); i++) begin
                assert (line[i] == byte_t'(exp_s[i])) else begin
                    $display("Fail tx_data byte %0d: got 0x%02h, expected 0x%02h",
                             i, line[i], exp_s[i]);
                    errors++;
                end
            end
        end
    endtask

    task automatic check_silence(input int cycles);
        int cnt;
        cnt = 0;
        while (cnt < cycles) begin
            @(negedge iClk);
            cnt++;
        end
        assert (tx_bytes.size() == 0 && !tx_valid) else begin
            $display("Error: %0d bytes were sent where no output was expected",
                     tx_bytes.size());
            errors++;
        end
        tx_bytes.delete();
    endtask

    task automatic log_result(input string name, input int err_start);
        tests_run++;
        if (errors > err_start) begin
            tests_failed++;
            $display("%-26s failed with %0d errors", name, errors - err_start);
        end else begin
            $display("%-26s passed", name);
        end
    endtask

    //////////////////////////////////////////////////
    // Directed tests

    task automatic reset_and_clock_report();
        int err_start;
        err_start = errors;
        @(negedge iClk);
        assert (tx_valid == 1'b0) else begin
            $display("Fail tx_valid after reset: got 0x%h, expected 0x0", tx_valid);
            errors++;
        end
        assert (rx_ready == 1'b1) else begin
            $display("Fail rx_ready after reset: got 0x%h, expected 0x1", rx_ready);
            errors++;
        end
        @(posedge iClk);
        digits <= to_digits("123456");
        send_cmd("C");
        compare_line(report_text("Clock ", "123456", "H ", "M ", "S"));
        log_result("reset and clock report", err_start);
    endtask

    task automatic reports_under_backpressure();
        int err_start;
        err_start = errors;
        @(posedge iClk);
        digits    <= to_digits("074519");
        bp_random <= 1'b1;
        send_cmd("W");
        compare_line(report_text("Stopwatch ", "074519", "M ", "S ", "mS"));
        @(posedge iClk);
        bp_random <= 1'b0;
        digits    <= to_digits("235901");
        send_cmd("T");
        compare_line(report_text("Timer ", "235901", "H ", "M ", "S"));
        log_result("reports with back-pressure", err_start);
    endtask

    task automatic setting_toggle();
        int err_start;
        err_start = errors;
        send_cmd("S");
        compare_line("Setting_On");
        send_cmd("S");
        compare_line("Setting_Off");
        send_cmd("X");     // Not a command
        check_silence(QUIET_CYCLES);
        log_result("setting and unknown byte", err_start);
    endtask

    task automatic stopwatch_buttons();
        int err_start;
        err_start = errors;
        @(posedge iClk);
        mode <= MODE_STOPWATCH;
        press_btn('{left: 1'b0, right: 1'b1});
        compare_line("Stop_Watch_RUN");
        press_btn('{left: 1'b0, right: 1'b1});
        compare_line("Stop_Watch_STOP");
        press_btn('{left: 1'b1, right: 1'b0});
        compare_line("Stop_Watch_Clear");
        // Clock mode ignores both buttons
        @(posedge iClk);
        mode <= MODE_CLOCK;
        press_btn('{left: 1'b0, right: 1'b1});
        press_btn('{left: 1'b1, right: 1'b0});
        check_silence(QUIET_CYCLES);
        log_result("stopwatch buttons", err_start);
    endtask

    task automatic timer_buttons();
        int err_start;
        err_start = errors;
        @(posedge iClk);
        mode   <= MODE_TIMER;
        set    <= 1'b0;
        digits <= to_digits("000130");
        press_btn('{left: 1'b0, right: 1'b1});
        compare_line("Timer_RUN");
        @(posedge iClk);
        digits <= to_digits("000000");
        press_btn('{left: 1'b0, right: 1'b1});
        compare_line("Timer_STOP");
        press_btn('{left: 1'b0, right: 1'b1});   // Zero count forces stop
        compare_line("Timer_STOP");
        press_btn('{left: 1'b1, right: 1'b0});
        compare_line("Timer_Clear");
        @(posedge iClk);
        set <= 1'b1;
        press_btn('{left: 1'b0, right: 1'b1});
        press_btn('{left: 1'b1, right: 1'b0});
        check_silence(QUIET_CYCLES);
        @(posedge iClk);
        set <= 1'b0;
        log_result("timer buttons", err_start);
    endtask

    //////////////////////////////////////////////////
    // Main sequence

    initial begin
        iRst         = 1'b1;
        rx_valid     = 1'b0;
        rx_data      = '0;
        mode         = MODE_CLOCK;
        set          = 1'b0;
        btn          = '0;
        digits       = to_digits("000000");
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        repeat (3) @(posedge iClk);
        iRst <= 1'b0;

        reset_and_clock_report();
        reports_under_backpressure();
        setting_toggle();
        stopwatch_buttons();
        timer_buttons();

        $display("Tests run: %0d, passed: %0d, failed: %0d, errors: %0d",
                 tests_run, tests_run - tests_failed, tests_failed, errors);
        if (errors == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

// ==== sim.f ====
hdl/msg_pkg.sv
hdl/request_decoder.sv
hdl/msg_builder.sv
hdl/tx_streamer.sv
hdl/uart_msg_top.sv
test/tb_uart_msg.sv

// ==== run_sim.sh ====
#!/bin/bash
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_uart_msg -f sim.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_uart_msg)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Test OK"; then
    exit 0
fi
exit 1
